/* source/exe_params.svh */
`ifndef EXE_PARAMS_SVH
`define EXE_PARAMS_SVH

// datapath and field widths
`define XLEN        32
`define REG_ADDR_W  5
`define ALU_OP_W    12
`define IMM_W       16
`define EXCODE_W    5

// exception codes, MIPS cause encoding
`define EX_NONE     5'd0
`define EX_ADEL     5'd4
`define EX_ADES     5'd5
`define EX_OV       5'd12

`endif

/* source/exe_pkg.sv */
`include "exe_params.svh"

package exe_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    // one-hot, bit 0 is add up to bit 11 lui
    typedef logic [`ALU_OP_W-1:0]   alu_op_t;
    typedef logic [`IMM_W-1:0]      imm_t;
    typedef logic [`EXCODE_W-1:0]   excode_t;
    // 0 byte, 1 half, 2 word
    typedef logic [1:0]             mem_size_t;

    typedef enum logic [1:0] {SRC1_RS, SRC1_SA, SRC1_PC} src1_sel_e;

    typedef enum logic [1:0] {SRC2_RT, SRC2_SIMM, SRC2_ZIMM, SRC2_EIGHT} src2_sel_e;

    typedef enum logic [3:0] {
        MEM_NONE, MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW, MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    typedef enum logic [2:0] {
        MD_NONE, MD_MULT, MD_MULTU, MD_MTHI, MD_MTLO, MD_MFHI, MD_MFLO
    } md_op_e;

    typedef enum logic {REQ_IDLE, REQ_WAIT} req_state_e;

endpackage

/* source/exe_op_if.sv */
`timescale 1ns/1ps

interface exe_op_if;
    import exe_pkg::*;

    // stage state
    logic      valid;
    logic      fresh;
    // latched instruction fields
    alu_op_t   alu_op;
    src1_sel_e src1_sel;
    src2_sel_e src2_sel;
    logic      ov_check;
    mem_op_e   mem_op;
    md_op_e    md_op;
    logic      gr_we;
    reg_addr_t dest;
    imm_t      imm;
    word_t     rs_value;
    word_t     rt_value;
    word_t     pc;

    modport stage (
        output valid, fresh, alu_op, src1_sel, src2_sel, ov_check, mem_op, md_op,
        output gr_we, dest, imm, rs_value, rt_value, pc
    );

    modport user (
        input valid, fresh, alu_op, src1_sel, src2_sel, ov_check, mem_op, md_op,
        input gr_we, dest, imm, rs_value, rt_value, pc
    );

endinterface

/* source/exe_input_reg.sv */
`timescale 1ns/1ps

module exe_input_reg (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    output logic               allowin,
    input  logic               leave,
    input  exe_pkg::alu_op_t   in_alu_op,
    input  exe_pkg::src1_sel_e in_src1_sel,
    input  exe_pkg::src2_sel_e in_src2_sel,
    input  logic               in_ov_check,
    input  exe_pkg::mem_op_e   in_mem_op,
    input  exe_pkg::md_op_e    in_md_op,
    input  logic               in_gr_we,
    input  exe_pkg::reg_addr_t in_dest,
    input  exe_pkg::imm_t      in_imm,
    input  exe_pkg::word_t     in_rs_value,
    input  exe_pkg::word_t     in_rt_value,
    input  exe_pkg::word_t     in_pc,
    exe_op_if.stage            op
);
    logic accept;

    // empty, or the current instruction leaves this cycle
    assign allowin = !op.valid || leave;
    assign accept  = in_valid && allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            op.valid <= 1'b0;
            op.fresh <= 1'b0;
        end else begin
            if (allowin) begin
                op.valid <= in_valid;
            end
            // first valid cycle of a new instruction
            op.fresh <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op.alu_op   <= in_alu_op;
            op.src1_sel <= in_src1_sel;
            op.src2_sel <= in_src2_sel;
            op.ov_check <= in_ov_check;
            op.mem_op   <= in_mem_op;
            op.md_op    <= in_md_op;
            op.gr_we    <= in_gr_we;
            op.dest     <= in_dest;
            op.imm      <= in_imm;
            op.rs_value <= in_rs_value;
            op.rt_value <= in_rt_value;
            op.pc       <= in_pc;
        end
    end

endmodule

/* source/exe_alu.sv */
`timescale 1ns/1ps
`include "exe_params.svh"

module exe_alu (
    exe_op_if.user         op,
    output exe_pkg::word_t result,
    output logic           overflow
);
    import exe_pkg::*;

    word_t      src1;
    word_t      src2;
    word_t      adder_b;
    word_t      sum;
    logic       carry;
    logic       adder_cin;
    logic       slt_bit;
    logic [4:0] shamt;

    always_comb begin
        case (op.src1_sel)
            SRC1_SA: src1 = {{(`XLEN-5){1'b0}}, op.imm[10:6]};
            SRC1_PC: src1 = op.pc;
            default: src1 = op.rs_value;
        endcase
    end

    always_comb begin
        case (op.src2_sel)
            SRC2_SIMM:  src2 = {{(`XLEN-`IMM_W){op.imm[`IMM_W-1]}}, op.imm};
            SRC2_ZIMM:  src2 = {{(`XLEN-`IMM_W){1'b0}}, op.imm};
            SRC2_EIGHT: src2 = word_t'(8);
            default:    src2 = op.rt_value;
        endcase
    end

    // sub, slt and sltu share the adder as a subtractor
    assign adder_cin = op.alu_op[1] | op.alu_op[2] | op.alu_op[3];
    assign adder_b   = adder_cin ? ~src2 : src2;
    assign {carry, sum} = {1'b0, src1} + {1'b0, adder_b} + {{`XLEN{1'b0}}, adder_cin};

    assign slt_bit = (src1[`XLEN-1] & ~src2[`XLEN-1])
                   | (~(src1[`XLEN-1] ^ src2[`XLEN-1]) & sum[`XLEN-1]);

    // signed overflow, operands agree in sign but the sum does not
    assign overflow = (op.alu_op[0] | op.alu_op[1])
                    & (src1[`XLEN-1] == adder_b[`XLEN-1])
                    & (sum[`XLEN-1] != src1[`XLEN-1]);

    assign shamt = src1[4:0];

    always_comb begin
        result = '0;
        if (op.alu_op[0] | op.alu_op[1]) result |= sum;
        if (op.alu_op[2])  result |= {{(`XLEN-1){1'b0}}, slt_bit};
        // borrow out means src1 below src2
        if (op.alu_op[3])  result |= {{(`XLEN-1){1'b0}}, ~carry};
        if (op.alu_op[4])  result |= src1 & src2;
        if (op.alu_op[5])  result |= ~(src1 | src2);
        if (op.alu_op[6])  result |= src1 | src2;
        if (op.alu_op[7])  result |= src1 ^ src2;
        if (op.alu_op[8])  result |= src2 << shamt;
        if (op.alu_op[9])  result |= src2 >> shamt;
        if (op.alu_op[10]) result |= word_t'($signed(src2) >>> shamt);
        if (op.alu_op[11]) result |= {src2[15:0], 16'b0};
    end

endmodule

/* source/mem_access.sv */
`timescale 1ns/1ps
`include "exe_params.svh"

module mem_access (
    exe_op_if.user             op,
    input  exe_pkg::word_t     addr,
    output exe_pkg::word_t     wdata,
    output exe_pkg::mem_size_t size,
    output logic               addr_err,
    output exe_pkg::excode_t   addr_excode
);
    import exe_pkg::*;

    logic is_load;
    logic word_access;
    logic half_access;

    assign is_load     = op.mem_op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
    assign word_access = op.mem_op inside {MEM_LW, MEM_SW};
    assign half_access = op.mem_op inside {MEM_LH, MEM_LHU, MEM_SH};

    // store lanes replicated so the memory picks by address
    always_comb begin
        case (op.mem_op)
            MEM_SB:  wdata = {4{op.rt_value[7:0]}};
            MEM_SH:  wdata = {2{op.rt_value[15:0]}};
            default: wdata = op.rt_value;
        endcase
    end

    assign size = word_access ? 2'd2 : half_access ? 2'd1 : 2'd0;

    assign addr_err = (word_access && addr[1:0] != 2'b00) || (half_access && addr[0]);

    always_comb begin
        if (!addr_err) begin
            addr_excode = `EX_NONE;
        end else if (is_load) begin
            addr_excode = `EX_ADEL;
        end else begin
            addr_excode = `EX_ADES;
        end
    end

endmodule

/* source/data_req_ctrl.sv */
`timescale 1ns/1ps

module data_req_ctrl (
    input  logic    clk,
    input  logic    reset,
    exe_op_if.user  op,
    input  logic    blocked,
    input  logic    leave,
    output logic    data_req,
    input  logic    data_addr_ok,
    output logic    mem_ready
);
    import exe_pkg::*;

    req_state_e state;
    logic       req_pending;
    logic       start;

    // request goes out on the first valid cycle
    assign start    = state == REQ_IDLE && op.fresh && op.mem_op != MEM_NONE && !blocked;
    assign data_req = start || (state == REQ_WAIT && req_pending);

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= REQ_IDLE;
            req_pending <= 1'b0;
            mem_ready   <= 1'b0;
        end else begin
            case (state)
                REQ_IDLE: begin
                    if (start) begin
                        state       <= REQ_WAIT;
                        req_pending <= !data_addr_ok;
                        mem_ready   <= data_addr_ok;
                    end
                end
                REQ_WAIT: begin
                    if (req_pending && data_addr_ok) begin
                        req_pending <= 1'b0;
                        mem_ready   <= 1'b1;
                    end else if (leave) begin
                        mem_ready <= 1'b0;
                        state     <= REQ_IDLE;
                    end
                end
                default: state <= REQ_IDLE;
            endcase
        end
    end

endmodule

/* source/hilo_unit.sv */
`timescale 1ns/1ps
`include "exe_params.svh"

module hilo_unit (
    input  logic           clk,
    input  logic           reset,
    exe_op_if.user         op,
    input  logic           commit,
    output exe_pkg::word_t hilo_value
);
    import exe_pkg::*;

    logic [2*`XLEN-1:0] signed_prod;
    logic [2*`XLEN-1:0] unsigned_prod;
    word_t              hi;
    word_t              lo;

    assign signed_prod   = $signed(op.rs_value) * $signed(op.rt_value);
    assign unsigned_prod = op.rs_value * op.rt_value;

    // written as the instruction leaves
    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (commit) begin
            case (op.md_op)
                MD_MULT:  {hi, lo} <= signed_prod;
                MD_MULTU: {hi, lo} <= unsigned_prod;
                MD_MTHI:  hi <= op.rs_value;
                MD_MTLO:  lo <= op.rs_value;
                default:  ;
            endcase
        end
    end

    assign hilo_value = (op.md_op == MD_MFHI) ? hi : lo;

endmodule

/* source/exe_stage.sv */
`timescale 1ns/1ps
`include "exe_params.svh"

module exe_stage (
    input  logic               clk,
    input  logic               reset,
    // from decode
    input  logic               ds_to_es_valid,
    output logic               es_allowin,
    input  exe_pkg::alu_op_t   ds_alu_op,
    input  exe_pkg::src1_sel_e ds_src1_sel,
    input  exe_pkg::src2_sel_e ds_src2_sel,
    input  exe_pkg::mem_op_e   ds_mem_op,
    input  exe_pkg::md_op_e    ds_md_op,
    input  logic               ds_ov_check,
    input  logic               ds_gr_we,
    input  exe_pkg::reg_addr_t ds_dest,
    input  exe_pkg::imm_t      ds_imm,
    input  exe_pkg::word_t     ds_rs_value,
    input  exe_pkg::word_t     ds_rt_value,
    input  exe_pkg::word_t     ds_pc,
    // to memory stage
    input  logic               ms_allowin,
    output logic               es_to_ms_valid,
    output exe_pkg::word_t     es_value,
    output logic               es_gr_we,
    output exe_pkg::reg_addr_t es_dest,
    output exe_pkg::word_t     es_pc,
    output exe_pkg::mem_op_e   es_mem_op,
    output logic               es_ex,
    output exe_pkg::excode_t   es_excode,
    output exe_pkg::word_t     es_badvaddr,
    // data memory port
    output logic               data_req,
    output logic               data_wr,
    output exe_pkg::mem_size_t data_size,
    output exe_pkg::word_t     data_addr,
    output exe_pkg::word_t     data_wdata,
    input  logic               data_addr_ok,
    // bypass to decode
    output exe_pkg::reg_addr_t es_fwd_dest
);
    import exe_pkg::*;

    exe_op_if op ();

    word_t   alu_result;
    word_t   hilo_value;
    excode_t addr_excode;
    logic    overflow;
    logic    ov_ex;
    logic    addr_err;
    logic    mem_ready;
    logic    ready_go;
    logic    leave;

    exe_input_reg u_input_reg (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (ds_to_es_valid),
        .allowin     (es_allowin),
        .leave       (leave),
        .in_alu_op   (ds_alu_op),
        .in_src1_sel (ds_src1_sel),
        .in_src2_sel (ds_src2_sel),
        .in_ov_check (ds_ov_check),
        .in_mem_op   (ds_mem_op),
        .in_md_op    (ds_md_op),
        .in_gr_we    (ds_gr_we),
        .in_dest     (ds_dest),
        .in_imm      (ds_imm),
        .in_rs_value (ds_rs_value),
        .in_rt_value (ds_rt_value),
        .in_pc       (ds_pc),
        .op          (op)
    );

    exe_alu u_alu (
        .op       (op),
        .result   (alu_result),
        .overflow (overflow)
    );

    mem_access u_mem_access (
        .op          (op),
        .addr        (alu_result),
        .wdata       (data_wdata),
        .size        (data_size),
        .addr_err    (addr_err),
        .addr_excode (addr_excode)
    );

    data_req_ctrl u_data_req_ctrl (
        .clk          (clk),
        .reset        (reset),
        .op           (op),
        .blocked      (es_ex),
        .leave        (leave),
        .data_req     (data_req),
        .data_addr_ok (data_addr_ok),
        .mem_ready    (mem_ready)
    );

    hilo_unit u_hilo (
        .clk        (clk),
        .reset      (reset),
        .op         (op),
        .commit     (leave && !es_ex),
        .hilo_value (hilo_value)
    );

    // faulting memory ops skip the request and leave at once
    assign ready_go       = (op.mem_op != MEM_NONE && !es_ex) ? mem_ready : 1'b1;
    assign es_to_ms_valid = op.valid && ready_go;
    assign leave          = es_to_ms_valid && ms_allowin;

    assign ov_ex       = overflow && op.ov_check;
    assign es_ex       = ov_ex || addr_err;
    assign es_excode   = ov_ex ? `EX_OV : addr_excode;
    assign es_badvaddr = alu_result;

    assign es_value  = (op.md_op inside {MD_MFHI, MD_MFLO}) ? hilo_value : alu_result;
    assign es_gr_we  = op.gr_we;
    assign es_dest   = op.dest;
    assign es_pc     = op.pc;
    assign es_mem_op = op.mem_op;

    assign data_wr   = op.mem_op inside {MEM_SB, MEM_SH, MEM_SW};
    assign data_addr = alu_result;

    assign es_fwd_dest = (op.valid && op.gr_we) ? op.dest : '0;

endmodule

/* dv/exe_stage_asserts.sv */
`timescale 1ns/1ps

module exe_stage_asserts (
    input logic               clk,
    input logic               reset,
    input logic               data_req,
    input logic               data_addr_ok,
    input logic               data_wr,
    input exe_pkg::mem_size_t data_size,
    input exe_pkg::word_t     data_addr,
    input exe_pkg::word_t     data_wdata,
    input logic               es_to_ms_valid,
    input logic               ms_allowin,
    input exe_pkg::word_t     es_value,
    input exe_pkg::reg_addr_t es_dest,
    input exe_pkg::word_t     es_pc,
    input logic               es_ex,
    input exe_pkg::excode_t   es_excode,
    input logic               addr_err
);

    // request stays up with stable fields until accepted
    req_hold: assert property (@(posedge clk) disable iff (reset)
        data_req && !data_addr_ok |=> data_req && $stable(data_addr) && $stable(data_wdata)
            && $stable(data_size) && $stable(data_wr))
        else $error("data_req dropped or changed before data_addr_ok");

    // outputs toward ms frozen while ms is not ready
    ms_hold: assert property (@(posedge clk) disable iff (reset)
        es_to_ms_valid && !ms_allowin |=> es_to_ms_valid && $stable(es_value)
            && $stable(es_dest) && $stable(es_pc) && $stable(es_ex) && $stable(es_excode))
        else $error("outputs toward ms changed under back-pressure");

    no_req_on_err: assert property (@(posedge clk) disable iff (reset)
        addr_err |-> !data_req)
        else $error("data_req raised for a misaligned access");

    reset_clears: assert property (@(posedge clk)
        reset |=> !es_to_ms_valid)
        else $error("es_to_ms_valid high right after reset");

endmodule

bind exe_stage exe_stage_asserts u_exe_stage_asserts (
    .clk            (clk),
    .reset          (reset),
    .data_req       (data_req),
    .data_addr_ok   (data_addr_ok),
    .data_wr        (data_wr),
    .data_size      (data_size),
    .data_addr      (data_addr),
    .data_wdata     (data_wdata),
    .es_to_ms_valid (es_to_ms_valid),
    .ms_allowin     (ms_allowin),
    .es_value       (es_value),
    .es_dest        (es_dest),
    .es_pc          (es_pc),
    .es_ex          (es_ex),
    .es_excode      (es_excode),
    .addr_err       (addr_err)
);

/* dv/exe_stage_tb.sv */
`timescale 1ns/1ps
`include "exe_params.svh"

module exe_stage_tb;
    import exe_pkg::*;

    // full run is roughly 500 cycles
    localparam int TIMEOUT_CYCLES = 2000;
    localparam alu_op_t OP_ADD = 12'h001;
    localparam alu_op_t OP_SUB = 12'h002;

    logic      clk = 1'b0;
    logic      reset;
    logic      ds_to_es_valid;
    logic      es_allowin;
    alu_op_t   ds_alu_op;
    src1_sel_e ds_src1_sel;
    src2_sel_e ds_src2_sel;
    mem_op_e   ds_mem_op;
    md_op_e    ds_md_op;
    logic      ds_ov_check;
    logic      ds_gr_we;
    reg_addr_t ds_dest;
    imm_t      ds_imm;
    word_t     ds_rs_value;
    word_t     ds_rt_value;
    word_t     ds_pc;
    logic      ms_allowin;
    logic      es_to_ms_valid;
    word_t     es_value;
    logic      es_gr_we;
    reg_addr_t es_dest;
    word_t     es_pc;
    mem_op_e   es_mem_op;
    logic      es_ex;
    excode_t   es_excode;
    word_t     es_badvaddr;
    logic      data_req;
    logic      data_wr;
    mem_size_t data_size;
    word_t     data_addr;
    word_t     data_wdata;
    logic      data_addr_ok;
    reg_addr_t es_fwd_dest;

    // captured on the leaving cycle
    word_t     got_value;
    word_t     got_badvaddr;
    logic      got_ex;
    excode_t   got_excode;
    reg_addr_t got_fwd;
    // captured by the memory responder
    int        req_count;
    logic      req_seen;
    word_t     req_addr;
    word_t     req_wdata;
    logic      req_wr;
    mem_size_t req_size;
    int        cycle_count = 0;
    int unsigned seed_draw;

    exe_stage exe_stage_i (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Regression failed");
            $fatal(1, "timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    // accepts each request after 0 to 3 cycles
    initial begin : mem_responder
        int ok_wait;
        ok_wait = -1;
        data_addr_ok = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            data_addr_ok = 1'b0;
            if (data_req) begin
                req_seen = 1'b1;
                if (ok_wait < 0) begin
                    ok_wait = $urandom_range(3, 0);
                end
                if (ok_wait == 0) begin
                    data_addr_ok = 1'b1;
                    req_count++;
                    req_addr  = data_addr;
                    req_wdata = data_wdata;
                    req_wr    = data_wr;
                    req_size  = data_size;
                end
                ok_wait--;
            end
        end
    end

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0d ns: %s got %h expected %h", $time, name, actual, expected);
            $display("Regression failed");
            $fatal(1, "stopping at the first wrong value");
        end
    endtask

    task automatic advance();
        @(posedge clk);
        #1;
    endtask

    task automatic set_fields(input alu_op_t alu, input src1_sel_e s1, input src2_sel_e s2,
                              input word_t rs, input word_t rt, input imm_t imm);
        ds_alu_op   = alu;
        ds_src1_sel = s1;
        ds_src2_sel = s2;
        ds_rs_value = rs;
        ds_rt_value = rt;
        ds_imm      = imm;
        ds_mem_op   = MEM_NONE;
        ds_md_op    = MD_NONE;
        ds_ov_check = 1'b0;
        ds_gr_we    = 1'b1;
        ds_dest     = reg_addr_t'($urandom_range(31, 1));
        ds_pc       = $urandom() & 32'hffff_fffc;
    endtask

    // offer the staged fields, wait for acceptance and for the leaving transfer
    task automatic run_op();
        req_count      = 0;
        req_seen       = 1'b0;
        ds_to_es_valid = 1'b1;
        while (!es_allowin) begin
            advance();
        end
        advance();
        ds_to_es_valid = 1'b0;
        while (!(es_to_ms_valid && ms_allowin)) begin
            advance();
        end
        got_value    = es_value;
        got_badvaddr = es_badvaddr;
        got_ex       = es_ex;
        got_excode   = es_excode;
        got_fwd      = es_fwd_dest;
        // decoded fields pass through to ms unchanged
        compare("es_gr_we", 32'(es_gr_we), 32'(ds_gr_we));
        compare("es_dest", 32'(es_dest), 32'(ds_dest));
        compare("es_pc", es_pc, ds_pc);
        compare("es_mem_op", 32'(es_mem_op), 32'(ds_mem_op));
        advance();
    endtask

    // reference result from the operand selects and the one-hot op index
    function automatic word_t alu_ref(input int idx);
        word_t a;
        word_t b;
        case (ds_src1_sel)
            SRC1_SA: a = {27'd0, ds_imm[10:6]};
            SRC1_PC: a = ds_pc;
            default: a = ds_rs_value;
        endcase
        case (ds_src2_sel)
            SRC2_SIMM:  b = {{16{ds_imm[15]}}, ds_imm};
            SRC2_ZIMM:  b = {16'd0, ds_imm};
            SRC2_EIGHT: b = 32'd8;
            default:    b = ds_rt_value;
        endcase
        case (idx)
            0:  return a + b;
            1:  return a - b;
            2:  return {31'd0, $signed(a) < $signed(b)};
            3:  return {31'd0, a < b};
            4:  return a & b;
            5:  return ~(a | b);
            6:  return a | b;
            7:  return a ^ b;
            8:  return b << a[4:0];
            9:  return b >> a[4:0];
            10: return word_t'($signed(b) >>> a[4:0]);
            default: return {b[15:0], 16'd0};
        endcase
    endfunction

    function automatic mem_size_t size_of(input mem_op_e m);
        if (m == MEM_LW || m == MEM_SW) return 2'd2;
        if (m inside {MEM_LH, MEM_LHU, MEM_SH}) return 2'd1;
        return 2'd0;
    endfunction

    function automatic logic is_store(input mem_op_e m);
        return m inside {MEM_SB, MEM_SH, MEM_SW};
    endfunction

    function automatic word_t store_data(input mem_op_e m, input word_t rt);
        if (m == MEM_SB) return {4{rt[7:0]}};
        if (m == MEM_SH) return {2{rt[15:0]}};
        return rt;
    endfunction

    task automatic alu_ops();
        word_t expected;
        for (int i = 0; i < 12; i++) begin
            for (int s1 = 0; s1 < 3; s1++) begin
                for (int s2 = 0; s2 < 4; s2++) begin
                    set_fields(alu_op_t'(12'b1 << i), src1_sel_e'(2'(s1)),
                               src2_sel_e'(2'(s2)), $urandom(), $urandom(),
                               imm_t'($urandom()));
                    expected = alu_ref(i);
                    run_op();
                    compare("es_value", got_value, expected);
                    compare("es_ex", 32'(got_ex), 32'd0);
                    compare("es_fwd_dest", 32'(got_fwd), 32'(ds_dest));
                end
            end
        end
    endtask

    task automatic overflow_cases();
        word_t rs;
        word_t expected;
        logic  is_sub;
        logic  ov_on;
        for (int k = 0; k < 4; k++) begin
            is_sub   = k[0];
            ov_on    = k[1];
            rs       = is_sub ? 32'h8000_0000 : 32'h7fff_ffff;
            expected = is_sub ? 32'h7fff_ffff : 32'h8000_0000;
            set_fields(is_sub ? OP_SUB : OP_ADD, SRC1_RS, SRC2_RT, rs, 32'd1, '0);
            ds_ov_check = ov_on;
            run_op();
            compare("es_ex", 32'(got_ex), 32'(ov_on));
            if (ov_on) begin
                compare("es_excode", 32'(got_excode), 32'(`EX_OV));
            end else begin
                compare("es_value", got_value, expected);
            end
        end
        // 5 + (-3) stays in range
        set_fields(OP_ADD, SRC1_RS, SRC2_RT, 32'd5, 32'hffff_fffd, '0);
        ds_ov_check = 1'b1;
        run_op();
        compare("es_ex", 32'(got_ex), 32'd0);
        compare("es_value", got_value, 32'd2);
    endtask

    task automatic mem_accesses();
        mem_op_e m;
        word_t   base;
        word_t   addr;
        word_t   rt;
        imm_t    imm;
        imm_t    mask;
        for (int k = 1; k <= 8; k++) begin
            m    = mem_op_e'(4'(k));
            mask = (size_of(m) == 2'd2) ? 16'hfffc : (size_of(m) == 2'd1) ? 16'hfffe : 16'hffff;
            for (int rep = 0; rep < 3; rep++) begin
                base = $urandom() & 32'hffff_fffc;
                imm  = imm_t'($urandom()) & mask;
                rt   = $urandom();
                addr = base + {{16{imm[15]}}, imm};
                set_fields(OP_ADD, SRC1_RS, SRC2_SIMM, base, rt, imm);
                ds_mem_op = m;
                ds_gr_we  = !is_store(m);
                run_op();
                compare("request count", 32'(req_count), 32'd1);
                compare("data_addr", req_addr, addr);
                compare("data_wr", 32'(req_wr), 32'(is_store(m)));
                compare("data_size", 32'(req_size), 32'(size_of(m)));
                compare("es_ex", 32'(got_ex), 32'd0);
                if (is_store(m)) begin
                    compare("data_wdata", req_wdata, store_data(m, rt));
                end
            end
        end
    endtask

    task automatic misaligned_accesses();
        mem_op_e m;
        word_t   base;
        word_t   addr;
        imm_t    imm;
        for (int k = 3; k <= 8; k++) begin
            // sb cannot be misaligned
            if (k == 6) continue;
            m = mem_op_e'(4'(k));
            for (int rep = 0; rep < 2; rep++) begin
                base = $urandom() & 32'hffff_fff0;
                if (size_of(m) == 2'd2) begin
                    imm = imm_t'($urandom_range(3, 1));
                end else begin
                    imm = imm_t'(2 * $urandom_range(1, 0) + 1);
                end
                addr = base + {16'd0, imm};
                set_fields(OP_ADD, SRC1_RS, SRC2_SIMM, base, $urandom(), imm);
                ds_mem_op = m;
                ds_gr_we  = !is_store(m);
                run_op();
                compare("data_req seen", 32'(req_seen), 32'd0);
                compare("es_ex", 32'(got_ex), 32'd1);
                compare("es_excode", 32'(got_excode),
                        is_store(m) ? 32'(`EX_ADES) : 32'(`EX_ADEL));
                compare("es_badvaddr", got_badvaddr, addr);
            end
        end
    endtask

    task automatic write_hilo(input md_op_e md, input word_t rs, input word_t rt);
        set_fields('0, SRC1_RS, SRC2_RT, rs, rt, '0);
        ds_md_op = md;
        ds_gr_we = 1'b0;
        run_op();
    endtask

    task automatic read_hilo(input md_op_e md, input word_t expected);
        set_fields('0, SRC1_RS, SRC2_RT, $urandom(), $urandom(), '0);
        ds_md_op = md;
        run_op();
        compare(md == MD_MFHI ? "es_value mfhi" : "es_value mflo", got_value, expected);
    endtask

    task automatic hilo_moves();
        word_t       rs;
        word_t       rt;
        logic [63:0] prod;
        for (int k = 0; k < 4; k++) begin
            rs = $urandom();
            rt = $urandom();
            if (k[0]) begin
                prod = {32'd0, rs} * {32'd0, rt};
            end else begin
                prod = {{32{rs[31]}}, rs} * {{32{rt[31]}}, rt};
            end
            write_hilo(k[0] ? MD_MULTU : MD_MULT, rs, rt);
            read_hilo(MD_MFHI, prod[63:32]);
            read_hilo(MD_MFLO, prod[31:0]);
        end
        rs = $urandom();
        rt = $urandom();
        write_hilo(MD_MTHI, rs, $urandom());
        write_hilo(MD_MTLO, rt, $urandom());
        read_hilo(MD_MFHI, rs);
        read_hilo(MD_MFLO, rt);
        // mthi leaves LO alone
        write_hilo(MD_MTHI, ~rs, $urandom());
        read_hilo(MD_MFLO, rt);
        read_hilo(MD_MFHI, ~rs);
    endtask

    task automatic backpressure_hold();
        word_t base;
        base = $urandom() & 32'hffff_fffc;
        set_fields(OP_ADD, SRC1_RS, SRC2_SIMM, base, $urandom(), 16'h0010);
        ds_mem_op = MEM_LW;
        ds_dest   = 5'd7;
        ms_allowin     = 1'b0;
        req_count      = 0;
        ds_to_es_valid = 1'b1;
        while (!es_allowin) begin
            advance();
        end
        advance();
        // next instruction waits in decode without gr_we
        set_fields(OP_ADD, SRC1_RS, SRC2_RT, 32'd100, 32'd23, '0);
        ds_gr_we = 1'b0;
        ds_dest  = 5'd9;
        while (!es_to_ms_valid) begin
            advance();
        end
        repeat (6) begin
            advance();
            compare("es_allowin", 32'(es_allowin), 32'd0);
            compare("es_to_ms_valid", 32'(es_to_ms_valid), 32'd1);
            compare("es_value", es_value, base + 32'h10);
            compare("es_dest", 32'(es_dest), 32'd7);
            compare("es_fwd_dest", 32'(es_fwd_dest), 32'd7);
            compare("data_req", 32'(data_req), 32'd0);
            compare("request count", 32'(req_count), 32'd1);
        end
        ms_allowin = 1'b1;
        advance();
        ds_to_es_valid = 1'b0;
        compare("es_value", es_value, 32'd123);
        compare("es_fwd_dest", 32'(es_fwd_dest), 32'd0);
        while (!(es_to_ms_valid && ms_allowin)) begin
            advance();
        end
        advance();
        // empty stage forwards nothing
        set_fields(OP_ADD, SRC1_RS, SRC2_RT, $urandom(), $urandom(), '0);
        run_op();
        compare("es_fwd_dest", 32'(es_fwd_dest), 32'd0);
    endtask

    initial begin
        seed_draw = $urandom(32'h353a229f);
        reset          = 1'b1;
        ds_to_es_valid = 1'b0;
        ms_allowin     = 1'b1;
        set_fields('0, SRC1_RS, SRC2_RT, '0, '0, '0);
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        compare("es_to_ms_valid", 32'(es_to_ms_valid), 32'd0);
        compare("data_req", 32'(data_req), 32'd0);
        alu_ops();
        overflow_cases();
        mem_accesses();
        misaligned_accesses();
        hilo_moves();
        backpressure_hold();
        $display("Regression passed");
        $finish;
    end

endmodule

/* build.f */
+incdir+source
source/exe_pkg.sv
source/exe_op_if.sv
source/exe_input_reg.sv
source/exe_alu.sv
source/mem_access.sv
source/data_req_ctrl.sv
source/hilo_unit.sv
source/exe_stage.sv
dv/exe_stage_asserts.sv
dv/exe_stage_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the exe_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module exe_stage_tb -f build.f --Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vexe_stage_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit 1
fi
exit 0
